//--- list.f
+incdir+hw
+incdir+sim
hw/stream_hub_pkg.sv
hw/msg_fifo.sv
hw/host_write_port.sv
hw/read_serializer.sv
hw/hub_ctrl_regs.sv
hw/stream_hub_top.sv
sim/stream_hub_assert.sv
sim/stream_hub_tb.sv

//--- Makefile
# Verilator build and run for the stream hub testbench

VERILATOR ?= verilator
TOP       ?= stream_hub_tb
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)

SRCS := $(filter %.sv %.v,$(shell cat $(FILELIST)))
HDRS := $(wildcard hw/*.svh sim/*.svh)
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(BUILD_DIR)

//--- sim/stream_hub_tests.svh
// ***************************************************************************
// Directed tests, called in order from the testbench
// ***************************************************************************

task automatic drain_read(input string test, input fpga_msg_t exp_q[$]);
  foreach (exp_q[i]) begin
    // Low word of each message goes out first
    for (int lane = 0; lane < `HUB_MSG_WORDS; lane++) begin
      wait_ready(test, SEL_READ);
      check(test, 64'(exp_q[i][lane*`HUB_WORD_W +: `HUB_WORD_W]), 64'(rd_data));
      rd_pop();
    end
  end
  @(negedge bus_clk);
  check(test, 64'h1, 64'(rd_empty));
endtask

task automatic test_reset_values();
  @(negedge bus_clk);
  check("reset", 64'h0, 64'({wr_full, pc_msg_pending, fpga_msg_full, rd_eof}));
  check("reset", 64'h3, 64'({rd_empty, loop_empty}));
  check("reset", 64'(LOOP_ON), 64'(status));
endtask

task automatic test_write_order();
  host_word_t exp_q[$];
  host_word_t w;
  // Loopback off, acks must leave the loopback FIFO empty
  ctrl_write('0);
  for (int i = 0; i < 10; i++) begin
    w = next_word();
    exp_q.push_back(w);
    host_write(w);
  end
  foreach (exp_q[i]) begin
    wait_ready("write_order", SEL_PENDING);
    check("write_order", 64'(exp_q[i]), 64'(pc_msg));
    app_ack();
  end
  @(negedge bus_clk);
  check("write_order", 64'h2, 64'({loop_empty, pc_msg_pending}));
  ctrl_write(LOOP_ON);
endtask

task automatic test_loopback();
  host_word_t exp_q[$];
  host_word_t w;
  for (int i = 0; i < 5; i++) begin
    w = next_word();
    exp_q.push_back(w);
    host_write(w);
    wait_ready("loopback", SEL_PENDING);
    app_ack();
    // Echo lands one cycle after the ack
    @(negedge bus_clk);
    check("loopback", 64'h0, 64'(loop_empty));
  end
  @(posedge bus_clk);
  wr_open <= 1'b0;
  @(negedge bus_clk);
  check("loopback", 64'h0, 64'(loop_eof));
  foreach (exp_q[i]) begin
    wait_ready("loopback", SEL_LOOP);
    check("loopback", 64'(exp_q[i]), 64'(loop_data));
    loop_pop();
  end
  @(negedge bus_clk);
  check("loopback", 64'h1, 64'(loop_eof));
  @(posedge bus_clk);
  wr_open <= 1'b1;
  @(negedge bus_clk);
  check("loopback", 64'h0, 64'(loop_eof));
endtask

task automatic test_read_serial();
  fpga_msg_t exp_q[$];
  fpga_msg_t m;
  // Sent while the host has the read stream closed
  @(posedge bus_clk);
  rd_open <= 1'b0;
  app_send({next_word(), next_word()});
  @(posedge bus_clk);
  rd_open <= 1'b1;
  for (int i = 0; i < 3; i++) begin
    m = {next_word(), next_word()};
    exp_q.push_back(m);
    app_send(m);
  end
  drain_read("read_serial", exp_q);
  repeat (4) @(negedge bus_clk);
  check("read_serial", 64'h1, 64'(rd_empty));
endtask

task automatic test_write_backpressure();
  host_word_t exp_q[$];
  host_word_t w;
  for (int i = 0; i < `HUB_FIFO_DEPTH; i++) begin
    w = next_word();
    exp_q.push_back(w);
    host_write(w);
  end
  @(negedge bus_clk);
  check("write_backpressure", 64'h1, 64'(wr_full));
  check("write_backpressure", 64'h0, 64'(status[STAT_WR_OVF]));
  host_write(~w);
  @(negedge bus_clk);
  check("write_backpressure", 64'h3, 64'({led[2], status[STAT_WR_OVF]}));
  ctrl_write(CLEAR_ON | LOOP_ON);
  @(negedge bus_clk);
  check("write_backpressure", 64'h0, 64'({led[2], status[STAT_WR_OVF]}));
  // Dropped word must not show up, acks refill the loopback FIFO
  foreach (exp_q[i]) begin
    wait_ready("write_backpressure", SEL_PENDING);
    check("write_backpressure", 64'(exp_q[i]), 64'(pc_msg));
    app_ack();
  end
  foreach (exp_q[i]) begin
    wait_ready("write_backpressure", SEL_LOOP);
    check("write_backpressure", 64'(exp_q[i]), 64'(loop_data));
    loop_pop();
  end
  @(negedge bus_clk);
  check("write_backpressure", 64'h0, 64'(wr_full));
endtask

task automatic test_read_overflow();
  fpga_msg_t exp_q[$];
  fpga_msg_t m;
  // FIFO entries plus the message held by the serializer
  for (int i = 0; i <= `HUB_FIFO_DEPTH; i++) begin
    m = {next_word(), next_word()};
    exp_q.push_back(m);
    app_send(m);
  end
  @(negedge bus_clk);
  check("read_overflow", 64'h1, 64'(fpga_msg_full));
  check("read_overflow", 64'h0, 64'(status[STAT_RD_OVF]));
  app_send(~m);
  @(negedge bus_clk);
  check("read_overflow", 64'h3, 64'({led[1], status[STAT_RD_OVF]}));
  ctrl_write(CLEAR_ON | LOOP_ON);
  @(negedge bus_clk);
  check("read_overflow", 64'h0, 64'(status[STAT_RD_OVF]));
  drain_read("read_overflow", exp_q);
endtask

task automatic test_end_of_file();
  host_write(32'hffff_fffe);
  repeat (2) @(negedge bus_clk);
  check("end_of_file", 64'h0, 64'(rd_eof));
  app_ack();
  host_write('1);
  @(negedge bus_clk);
  check("end_of_file", 64'h0, 64'(rd_eof));
  @(negedge bus_clk);
  check("end_of_file", 64'h3, 64'({rd_eof, led[3]}));
  app_ack();
  repeat (2) @(negedge bus_clk);
  check("end_of_file", 64'h0, 64'(rd_eof));
  // Both words were echoed
  repeat (2) begin
    wait_ready("end_of_file", SEL_LOOP);
    loop_pop();
  end
endtask

//--- sim/stream_hub_tb.sv
`include "stream_hub_params.svh"

module stream_hub_tb;

  import stream_hub_pkg::*;

  localparam int CLK_PERIOD   = 100;
  localparam int RESET_CYCLES = 3;
  localparam int WAIT_LIMIT   = 40;
  // Rough cycle cost of each test, in run order
  localparam int TEST_CYCLES  = 10 + 80 + 70 + 50 + 180 + 190 + 40;
  localparam int WATCHDOG_CYCLES = 4 * TEST_CYCLES;

  localparam int SEL_PENDING = 0;
  localparam int SEL_LOOP    = 1;
  localparam int SEL_READ    = 2;
  localparam int STAT_WR_OVF = 2;
  localparam int STAT_RD_OVF = 3;

  localparam ctrl_word_t LOOP_ON  = ctrl_word_t'(1) << `HUB_CTRL_LOOP;
  localparam ctrl_word_t CLEAR_ON = ctrl_word_t'(1) << `HUB_CTRL_CLEAR;

  logic bus_clk, rst_n, wr_wren, wr_open, wr_full, pc_msg_pending, pc_msg_ack;
  logic loop_rden, loop_empty, loop_eof, fpga_msg_valid, fpga_msg_full;
  logic rd_open, rd_rden, rd_empty, rd_eof, ctrl_wr;
  host_word_t  wr_data, pc_msg, loop_data, rd_data;
  fpga_msg_t   fpga_msg;
  ctrl_word_t  ctrl_data, status;
  logic [3:0]  led;
  logic [31:0] lcg_state;

  stream_hub_top dut0 (.*);

  initial begin
    bus_clk = 1'b0;
    forever #(CLK_PERIOD / 2) bus_clk = ~bus_clk;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    abort_run("watchdog expired before the tests finished");
  end

  function automatic host_word_t next_word();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic flag_ready(input int sel);
    case (sel)
      SEL_PENDING: return pc_msg_pending;
      SEL_LOOP:    return !loop_empty;
      default:     return !rd_empty;
    endcase
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("** FAIL **");
    $fatal(1, "run aborted");
  endtask

  task automatic check(input string test, input logic [63:0] expected,
                       input logic [63:0] actual);
    if (expected !== actual) begin
      abort_run($sformatf("mismatch in %s: expected %h, actual %h", test, expected, actual));
    end
  endtask

  // Polls on the falling edge, where outputs have settled
  task automatic wait_ready(input string test, input int sel);
    int n;
    n = 0;
    @(negedge bus_clk);
    while (!flag_ready(sel)) begin
      if (n == WAIT_LIMIT) begin
        abort_run($sformatf("%s: stream not ready after %0d cycles", test, WAIT_LIMIT));
      end else begin
        n++;
        @(negedge bus_clk);
      end
    end
  endtask

  // ***************************************************************************
  // Drivers, each one strobe seen by the DUT on one edge
  // ***************************************************************************

  task automatic host_write(input host_word_t w);
    @(posedge bus_clk);
    wr_wren <= 1'b1;
    wr_data <= w;
    @(posedge bus_clk);
    wr_wren <= 1'b0;
  endtask

  task automatic app_ack();
    @(posedge bus_clk);
    pc_msg_ack <= 1'b1;
    @(posedge bus_clk);
    pc_msg_ack <= 1'b0;
  endtask

  task automatic loop_pop();
    @(posedge bus_clk);
    loop_rden <= 1'b1;
    @(posedge bus_clk);
    loop_rden <= 1'b0;
  endtask

  task automatic rd_pop();
    @(posedge bus_clk);
    rd_rden <= 1'b1;
    @(posedge bus_clk);
    rd_rden <= 1'b0;
  endtask

  task automatic app_send(input fpga_msg_t m);
    @(posedge bus_clk);
    fpga_msg_valid <= 1'b1;
    fpga_msg       <= m;
    @(posedge bus_clk);
    fpga_msg_valid <= 1'b0;
  endtask

  task automatic ctrl_write(input ctrl_word_t d);
    @(posedge bus_clk);
    ctrl_wr   <= 1'b1;
    ctrl_data <= d;
    @(posedge bus_clk);
    ctrl_wr   <= 1'b0;
  endtask

  `include "stream_hub_tests.svh"

  initial begin
    rst_n          = 1'b0;
    wr_wren        = 1'b0;
    wr_data        = '0;
    wr_open        = 1'b1;
    pc_msg_ack     = 1'b0;
    loop_rden      = 1'b0;
    fpga_msg_valid = 1'b0;
    fpga_msg       = '0;
    rd_open        = 1'b1;
    rd_rden        = 1'b0;
    ctrl_wr        = 1'b0;
    ctrl_data      = '0;
    lcg_state      = 32'h9b21ff80;
    repeat (RESET_CYCLES) @(posedge bus_clk);
    rst_n <= 1'b1;
    test_reset_values();
    test_write_order();
    test_loopback();
    test_read_serial();
    test_write_backpressure();
    test_read_overflow();
    test_end_of_file();
    @(negedge bus_clk);
    if (dut0.u_assert.error_count != 0) begin
      abort_run("one or more assertions failed during the run");
    end else begin
      $display("** PASS **");
      $finish;
    end
  end

endmodule

//--- sim/stream_hub_assert.sv
`include "stream_hub_params.svh"

module stream_hub_assert (
  input logic                                bus_clk,
  input logic                                rst_n,
  input logic                                wr_full,
  input logic [$clog2(`HUB_FIFO_DEPTH)-1:0]  wfifo_wr_ptr,
  input logic                                pc_msg_pending,
  input logic                                pc_msg_ack,
  input stream_hub_pkg::host_word_t          pc_msg,
  input logic                                rd_eof
);

  // Failures seen so far, read back by the testbench at the end
  int unsigned error_count = 0;

  // Head word holds until the application takes it
  a_head_stable: assert property (@(posedge bus_clk) disable iff (!rst_n)
    pc_msg_pending && !pc_msg_ack |=> $stable(pc_msg))
  else begin
    $error("pc_msg changed while pending and not acked");
    error_count++;
  end

  // End of file is the all-ones pending word, one cycle late
  a_eof_follows: assert property (@(posedge bus_clk) disable iff (!rst_n)
    1'b1 |=> (rd_eof == $past(pc_msg_pending && (&pc_msg))))
  else begin
    $error("rd_eof does not follow the all-ones pending word");
    error_count++;
  end

  // Write FIFO must not advance on an edge where the host saw full
  a_no_write_when_full: assert property (@(posedge bus_clk) disable iff (!rst_n)
    wr_full |=> $stable(wfifo_wr_ptr))
  else begin
    $error("host word accepted while wr_full was high");
    error_count++;
  end

endmodule

bind stream_hub_top stream_hub_assert u_assert (
  .bus_clk        (bus_clk),
  .rst_n          (rst_n),
  .wr_full        (wr_full),
  .wfifo_wr_ptr   (wr_fifo.wr_ptr),
  .pc_msg_pending (pc_msg_pending),
  .pc_msg_ack     (pc_msg_ack),
  .pc_msg         (pc_msg),
  .rd_eof         (rd_eof)
);

//--- hw/stream_hub_top.sv
module stream_hub_top (
  input  logic                       bus_clk,
  input  logic                       rst_n,
  // Host write stream
  input  logic                       wr_wren,
  input  stream_hub_pkg::host_word_t wr_data,
  input  logic                       wr_open,
  output logic                       wr_full,
  // Application receive side
  output logic                       pc_msg_pending,
  output stream_hub_pkg::host_word_t pc_msg,
  input  logic                       pc_msg_ack,
  // Loopback stream
  input  logic                       loop_rden,
  output logic                       loop_empty,
  output stream_hub_pkg::host_word_t loop_data,
  output logic                       loop_eof,
  // Application send side
  input  logic                       fpga_msg_valid,
  input  stream_hub_pkg::fpga_msg_t  fpga_msg,
  output logic                       fpga_msg_full,
  // Host read stream
  input  logic                       rd_open,
  input  logic                       rd_rden,
  output logic                       rd_empty,
  output stream_hub_pkg::host_word_t rd_data,
  output logic                       rd_eof,
  // Control
  input  logic                       ctrl_wr,
  input  stream_hub_pkg::ctrl_word_t ctrl_data,
  output stream_hub_pkg::ctrl_word_t status,
  output logic [3:0]                 led
);

  import stream_hub_pkg::*;

  logic       wfifo_push;
  logic       wfifo_empty;
  logic       wfifo_full;
  logic       lfifo_push;
  logic       lfifo_full;
  logic       ack_valid;
  logic       loop_enable;
  logic       clear_errors;
  logic       wr_overflow;
  logic       rfifo_push;
  logic       rfifo_pop;
  logic       rfifo_empty;
  logic       rd_overflow_event;
  fpga_msg_t  rfifo_head;

  // ***************************************************************************
  // Host to application, with loopback echo
  // ***************************************************************************

  // Ack only counts while a word is shown
  assign ack_valid      = pc_msg_ack && pc_msg_pending;
  assign pc_msg_pending = !wfifo_empty;

  host_write_port u_host_write_port (
    .bus_clk      (bus_clk),
    .rst_n        (rst_n),
    .wr_wren      (wr_wren),
    .wfifo_full   (wfifo_full),
    .lfifo_full   (lfifo_full),
    .loop_enable  (loop_enable),
    .pc_msg_ack   (ack_valid),
    .clear_errors (clear_errors),
    .wr_full      (wr_full),
    .wfifo_push   (wfifo_push),
    .lfifo_push   (lfifo_push),
    .wr_overflow  (wr_overflow)
  );

  msg_fifo #(.payload_t(host_word_t)) wr_fifo (
    .bus_clk   (bus_clk),
    .rst_n     (rst_n),
    .push      (wfifo_push),
    .push_data (wr_data),
    .pop       (ack_valid),
    .head      (pc_msg),
    .empty     (wfifo_empty),
    .full      (wfifo_full)
  );

  msg_fifo #(.payload_t(host_word_t)) loop_fifo (
    .bus_clk   (bus_clk),
    .rst_n     (rst_n),
    .push      (lfifo_push),
    .push_data (pc_msg),
    .pop       (loop_rden),
    .head      (loop_data),
    .empty     (loop_empty),
    .full      (lfifo_full)
  );

  // Loopback closes once the writer is gone and everything is drained
  assign loop_eof = !wr_open && loop_empty;

  // ***************************************************************************
  // Application to host read stream
  // ***************************************************************************

  // Closed read stream swallows messages without complaint
  assign rfifo_push        = fpga_msg_valid && rd_open && !fpga_msg_full;
  assign rd_overflow_event = fpga_msg_valid && rd_open && fpga_msg_full;

  msg_fifo #(.payload_t(fpga_msg_t)) rd_fifo (
    .bus_clk   (bus_clk),
    .rst_n     (rst_n),
    .push      (rfifo_push),
    .push_data (fpga_msg),
    .pop       (rfifo_pop),
    .head      (rfifo_head),
    .empty     (rfifo_empty),
    .full      (fpga_msg_full)
  );

  read_serializer u_read_serializer (
    .bus_clk   (bus_clk),
    .rst_n     (rst_n),
    .msg_empty (rfifo_empty),
    .msg_head  (rfifo_head),
    .rd_rden   (rd_rden),
    .msg_pop   (rfifo_pop),
    .rd_empty  (rd_empty),
    .rd_data   (rd_data)
  );

  // All-ones pending word marks end of the read file
  always_ff @(posedge bus_clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_eof <= 1'b0;
    end else begin
      rd_eof <= pc_msg_pending && (&pc_msg);
    end
  end

  hub_ctrl_regs u_hub_ctrl_regs (
    .bus_clk           (bus_clk),
    .rst_n             (rst_n),
    .ctrl_wr           (ctrl_wr),
    .ctrl_data         (ctrl_data),
    .wr_overflow       (wr_overflow),
    .rd_overflow_event (rd_overflow_event),
    .rd_eof            (rd_eof),
    .loop_enable       (loop_enable),
    .clear_errors      (clear_errors),
    .status            (status),
    .led               (led)
  );

endmodule

//--- hw/hub_ctrl_regs.sv
`include "stream_hub_params.svh"

module hub_ctrl_regs (
  input  logic                     bus_clk,
  input  logic                     rst_n,
  input  logic                     ctrl_wr,
  input  stream_hub_pkg::ctrl_word_t ctrl_data,
  input  logic                     wr_overflow,
  input  logic                     rd_overflow_event,
  input  logic                     rd_eof,
  output logic                     loop_enable,
  output logic                     clear_errors,
  output stream_hub_pkg::ctrl_word_t status,
  output logic [3:0]               led
);

  // Status bits for the overflow flags
  localparam int STAT_WR_OVF = 2;
  localparam int STAT_RD_OVF = 3;

  logic rd_overflow;

  // One-cycle pulse, acts on the flags at the next edge
  assign clear_errors = ctrl_wr && ctrl_data[`HUB_CTRL_CLEAR];

  // ***************************************************************************
  // Stored control bits and the read overflow flag
  // ***************************************************************************

  always_ff @(posedge bus_clk or negedge rst_n) begin
    if (!rst_n) begin
      loop_enable <= 1'b1;
    end else if (ctrl_wr) begin
      loop_enable <= ctrl_data[`HUB_CTRL_LOOP];
    end
  end

  // New event beats a clear in the same cycle
  always_ff @(posedge bus_clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_overflow <= 1'b0;
    end else if (rd_overflow_event) begin
      rd_overflow <= 1'b1;
    end else if (clear_errors) begin
      rd_overflow <= 1'b0;
    end
  end

  // ***************************************************************************
  // Readback and LEDs
  // ***************************************************************************

  always_comb begin
    status                 = '0;
    status[`HUB_CTRL_LOOP] = loop_enable;
    status[STAT_WR_OVF]    = wr_overflow;
    status[STAT_RD_OVF]    = rd_overflow;
  end

  // Board LEDs, msb first
  assign led = {rd_eof, wr_overflow, rd_overflow, loop_enable};

endmodule

//--- hw/read_serializer.sv
`include "stream_hub_params.svh"

module read_serializer (
  input  logic                     bus_clk,
  input  logic                     rst_n,
  input  logic                     msg_empty,
  input  stream_hub_pkg::fpga_msg_t  msg_head,
  input  logic                     rd_rden,
  output logic                     msg_pop,
  output logic                     rd_empty,
  output stream_hub_pkg::host_word_t rd_data
);

  import stream_hub_pkg::*;

  localparam int LANES  = `HUB_MSG_WORDS;
  localparam int LANE_W = (LANES > 1) ? $clog2(LANES) : 1;

  fpga_msg_t         msg_q;
  logic              held;
  logic [LANE_W-1:0] lane;
  logic              last_lane;
  logic              take;
  logic              take_last;

  assign last_lane = (lane == LANE_W'(LANES - 1));
  assign take      = held && rd_rden;
  assign take_last = take && last_lane;

  // Load when idle, or straight after the last lane goes out
  assign msg_pop = (!held || take_last) && !msg_empty;

  assign rd_empty = !held;

  // Lane 0 is the low word
  assign rd_data = msg_q[lane*`HUB_WORD_W +: `HUB_WORD_W];

  // ***************************************************************************
  // Holding register and lane index
  // ***************************************************************************

  always_ff @(posedge bus_clk) begin
    if (msg_pop) begin
      msg_q <= msg_head;
    end
  end

  always_ff @(posedge bus_clk or negedge rst_n) begin
    if (!rst_n) begin
      held <= 1'b0;
      lane <= '0;
    end else if (msg_pop) begin
      held <= 1'b1;
      lane <= '0;
    end else if (take_last) begin
      // Nothing waiting, go idle
      held <= 1'b0;
      lane <= '0;
    end else if (take) begin
      lane <= lane + 1'b1;
    end
  end

endmodule

//--- hw/host_write_port.sv
module host_write_port (
  input  logic bus_clk,
  input  logic rst_n,
  input  logic wr_wren,
  input  logic wfifo_full,
  input  logic lfifo_full,
  input  logic loop_enable,
  input  logic pc_msg_ack,
  input  logic clear_errors,
  output logic wr_full,
  output logic wfifo_push,
  output logic lfifo_push,
  output logic wr_overflow
);

  logic drop;

  // ***************************************************************************
  // Host write acceptance
  // ***************************************************************************

  // Loopback FIFO only throttles the host while loopback is on
  assign wr_full = wfifo_full || (loop_enable && lfifo_full);

  assign wfifo_push = wr_wren && !wr_full;

  // Word presented against a full flag is lost
  assign drop = wr_wren && wr_full;

  // Echo each popped word back to the host
  assign lfifo_push = pc_msg_ack && loop_enable;

  // ***************************************************************************
  // Sticky overflow flag
  // ***************************************************************************

  // A drop in the clearing cycle still wins
  always_ff @(posedge bus_clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_overflow <= 1'b0;
    end else if (drop) begin
      wr_overflow <= 1'b1;
    end else if (clear_errors) begin
      wr_overflow <= 1'b0;
    end
  end

endmodule

//--- hw/msg_fifo.sv
`include "stream_hub_params.svh"

module msg_fifo #(
  parameter type payload_t = stream_hub_pkg::host_word_t
) (
  input  logic     bus_clk,
  input  logic     rst_n,
  input  logic     push,
  input  payload_t push_data,
  input  logic     pop,
  output payload_t head,
  output logic     empty,
  output logic     full
);

  localparam int DEPTH = `HUB_FIFO_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  payload_t         mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             do_push;
  logic             do_pop;

  // Strobes are ignored when they cannot be honoured
  assign do_push = push && !full;
  assign do_pop  = pop && !empty;

  assign empty = (count == '0);
  assign full  = (count == CNT_W'(DEPTH));

  // First word fall through
  assign head = mem[rd_ptr];

  always_ff @(posedge bus_clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  always_ff @(posedge bus_clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // Simultaneous push and pop leaves occupancy as is
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

//--- hw/stream_hub_pkg.sv
`include "stream_hub_params.svh"

package stream_hub_pkg;

  // One word on any host stream
  typedef logic [`HUB_WORD_W-1:0] host_word_t;

  // Application message with lane 0 in the low bits
  typedef logic [`HUB_MSG_WORDS*`HUB_WORD_W-1:0] fpga_msg_t;

  // Control register image as written and as read back
  typedef logic [31:0] ctrl_word_t;

endpackage

//--- hw/stream_hub_params.svh
`ifndef STREAM_HUB_PARAMS_SVH
`define STREAM_HUB_PARAMS_SVH

// ***************************************************************************
// Stream geometry
// ***************************************************************************

// Width of one word on the host streams
`define HUB_WORD_W 32

// Host words per application message
`define HUB_MSG_WORDS 2

// Entries in every hub FIFO
`define HUB_FIFO_DEPTH 16

// ***************************************************************************
// Control register bit positions
// ***************************************************************************

// Clear-errors pulse, never stored
`define HUB_CTRL_CLEAR 0

// Loopback enable, also reported at the same status bit
`define HUB_CTRL_LOOP 1

`endif
